//--- src/fp_max_defs.svh
`ifndef FP_MAX_DEFS_SVH
`define FP_MAX_DEFS_SVH

// Single-precision sample layout
`define FP_DATA_WIDTH 32
`define FP_EXP_WIDTH 8

// Samples per window, at least 2
`define FP_WINDOW_LEN 8

// Must hold FP_WINDOW_LEN-1
`define FP_INDEX_WIDTH 3

`endif

//--- src/fp_max_pkg.sv
`include "fp_max_defs.svh"

package fp_max_pkg;

	//////////////////////////////////////////////////
	// Basic vectors

	// Raw IEEE-754 single-precision word
	typedef logic [`FP_DATA_WIDTH-1:0] fp_word_t;

	// Position of a sample inside its window
	typedef logic [`FP_INDEX_WIDTH-1:0] win_index_t;

	//////////////////////////////////////////////////
	// Compound types

	// Value tagged with its window position
	typedef struct packed {
		fp_word_t value;
		win_index_t index;
	} fp_item_t;

	// Window sequencing
	typedef enum logic [1:0] {
		IDLE,
		ACCUM,
		DRAIN
	} ctrl_state_t;

endpackage

//--- src/fp_comp.sv
`timescale 1ns/1ps
`include "fp_max_defs.svh"

module fp_comp (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input fp_max_pkg::fp_item_t in_a,
	input fp_max_pkg::fp_item_t in_b,
	output fp_max_pkg::fp_item_t best,
	output logic valid_out
);
	import fp_max_pkg::*;

	localparam int FRAC_WIDTH = `FP_DATA_WIDTH - 1 - `FP_EXP_WIDTH;

	// Field split of both operands
	logic sign_a;
	logic sign_b;
	logic [`FP_EXP_WIDTH-1:0] exp_a;
	logic [`FP_EXP_WIDTH-1:0] exp_b;
	logic [FRAC_WIDTH-1:0] frac_a;
	logic [FRAC_WIDTH-1:0] frac_b;
	logic mag_a_gt;
	logic mag_b_gt;
	logic pick_b;

	assign {sign_a, exp_a, frac_a} = in_a.value;
	assign {sign_b, exp_b, frac_b} = in_b.value;

	// Magnitude order, exponent first then fraction
	assign mag_a_gt = (exp_a > exp_b) || ((exp_a == exp_b) && (frac_a > frac_b));
	assign mag_b_gt = (exp_b > exp_a) || ((exp_b == exp_a) && (frac_b > frac_a));

	// Only a strictly greater b replaces a, ties stay with a
	always_comb begin
		if (sign_a != sign_b) begin
			// Positive side wins, so +0 beats -0
			pick_b = sign_a;
		end else if (!sign_a) begin
			pick_b = mag_b_gt;
		end else begin
			// Both negative, smaller magnitude is larger
			pick_b = mag_a_gt;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			best <= '0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
			// Hold best while idle
			if (valid_in)
				best <= pick_b ? in_b : in_a;
		end
	end

endmodule

//--- src/window_counter.sv
`timescale 1ns/1ps
`include "fp_max_defs.svh"

module window_counter (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic take,
	output fp_max_pkg::win_index_t index,
	output logic last
);
	import fp_max_pkg::*;

	localparam win_index_t LAST_INDEX = win_index_t'(`FP_WINDOW_LEN - 1);

	// Accepted samples so far in this window
	win_index_t count;

	//////////////////////////////////////////////////
	// Count register

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			// Abort drops the partial window
			count <= '0;
		end else if (take) begin
			// Explicit wrap, length need not be a power of two
			if (last)
				count <= '0;
			else
				count <= count + win_index_t'(1);
		end
	end

	//////////////////////////////////////////////////
	// Outputs

	assign index = count;

	// Next accepted sample closes the window
	assign last = (count == LAST_INDEX);

endmodule

//--- src/reduce_ctrl.sv
`timescale 1ns/1ps

module reduce_ctrl (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic abort,
	input logic last,
	output logic take,
	output logic first,
	output logic clear,
	output logic result_load,
	output logic busy
);
	import fp_max_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	//////////////////////////////////////////////////
	// Strobes

	// Abort masks the sample in any state
	assign take = sample_valid && !abort;

	// Sample that opens a fresh window
	assign first = take && (state != ACCUM);

	// Counter is already zero outside ACCUM, so abort alone is enough
	assign clear = abort;

	// Window complete, best holds its maximum
	assign result_load = (state == DRAIN);

	assign busy = (state != IDLE);

	//////////////////////////////////////////////////
	// Next state

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (take)
					state_next = ACCUM;
			end
			ACCUM: begin
				if (abort) begin
					// Partial window discarded, no result
					state_next = IDLE;
				end else if (take && last) begin
					state_next = DRAIN;
				end
			end
			DRAIN: begin
				// Single cycle, result goes out regardless of abort
				// A sample here is index 0 of the next window
				if (take)
					state_next = ACCUM;
				else
					state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// State register

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

endmodule

//--- src/max_accum.sv
`timescale 1ns/1ps

module max_accum (
	input logic clk,
	input logic reset,
	input logic take,
	input logic first,
	input logic result_load,
	input fp_max_pkg::fp_word_t sample,
	input fp_max_pkg::win_index_t index,
	input fp_max_pkg::fp_item_t best,
	output logic cmp_valid,
	output fp_max_pkg::fp_item_t cmp_a,
	output fp_max_pkg::fp_item_t cmp_b,
	output fp_max_pkg::fp_item_t result,
	output logic result_valid
);
	import fp_max_pkg::*;

	// Incoming sample tagged with its position
	fp_item_t item_in;

	// Window maximum caught before the next window overwrites best
	fp_item_t held;
	logic held_pend;

	//////////////////////////////////////////////////
	// Comparator operands

	assign item_in.value = sample;
	assign item_in.index = index;

	// Comparator fires once per accepted sample
	assign cmp_valid = take;

	// First sample compared against itself loads unchanged
	assign cmp_a = first ? item_in : best;
	assign cmp_b = item_in;

	//////////////////////////////////////////////////
	// Result path

	// Capture on the drain cycle, best may restart on the same edge
	always_ff @(posedge clk) begin
		if (result_load)
			held <= best;
	end

	// Output stage, result and valid change together
	always_ff @(posedge clk) begin
		if (reset) begin
			held_pend <= 1'b0;
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			held_pend <= result_load;
			result_valid <= held_pend;
			if (held_pend)
				result <= held;
		end
	end

endmodule

//--- src/fp_max_top.sv
`timescale 1ns/1ps

module fp_max_top (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input fp_max_pkg::fp_word_t sample,
	input logic abort,
	output fp_max_pkg::fp_item_t result,
	output logic result_valid,
	output logic busy
);
	import fp_max_pkg::*;

	//////////////////////////////////////////////////
	// Internal nets

	// Controller strobes
	logic take;
	logic first;
	logic clear;
	logic result_load;

	// Window position
	win_index_t index;
	logic last;

	// Comparator loop
	logic cmp_valid;
	fp_item_t cmp_a;
	fp_item_t cmp_b;
	fp_item_t best;

	//////////////////////////////////////////////////
	// Instances

	reduce_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.abort(abort),
		.last(last),
		.take(take),
		.first(first),
		.clear(clear),
		.result_load(result_load),
		.busy(busy)
	);

	window_counter u_counter (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.take(take),
		.index(index),
		.last(last)
	);

	max_accum u_accum (
		.clk(clk),
		.reset(reset),
		.take(take),
		.first(first),
		.result_load(result_load),
		.sample(sample),
		.index(index),
		.best(best),
		.cmp_valid(cmp_valid),
		.cmp_a(cmp_a),
		.cmp_b(cmp_b),
		.result(result),
		.result_valid(result_valid)
	);

	// Registered compare, output is the running maximum
	fp_comp u_comp (
		.clk(clk),
		.reset(reset),
		.valid_in(cmp_valid),
		.in_a(cmp_a),
		.in_b(cmp_b),
		.best(best),
		.valid_out()
	);

endmodule

//--- bench/tb_fp_max.sv
`timescale 1ns/1ps
`include "fp_max_defs.svh"

module tb_fp_max;
	import fp_max_pkg::*;

	// Posedges allowed while waiting for results
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic sample_valid;
	fp_word_t sample;
	logic abort;
	fp_item_t result;
	logic result_valid;
	logic busy;

	// Current window and result queues
	fp_word_t win_buf [`FP_WINDOW_LEN];
	fp_item_t exp_q [$];
	fp_item_t got_q [$];
	logic [31:0] rng_state = 32'hb624_34f2;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	fp_max_top u_dut (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample(sample),
		.abort(abort),
		.result(result),
		.result_valid(result_valid),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Results caught on the falling edge, where they are stable
	always @(negedge clk) begin
		if (result_valid)
			got_q.push_back(result);
	end

	//////////////////////////////////////////////////
	// Reference model

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Exponent 120..135 and a coarse fraction, so ties happen now and then
	function automatic fp_word_t rand_word();
		logic [31:0] r;
		r = next_rand();
		return {r[31], 8'd120 + {4'd0, r[27:24]}, r[22:19], 19'd0};
	endfunction

	// Unsigned key in float order, positives above negatives
	// Negative magnitudes inverted so the smallest one ranks highest
	function automatic logic [`FP_DATA_WIDTH-1:0] order_key(input fp_word_t w);
		if (w[`FP_DATA_WIDTH-1])
			return {1'b0, ~w[`FP_DATA_WIDTH-2:0]};
		return {1'b1, w[`FP_DATA_WIDTH-2:0]};
	endfunction

	// Strictly greater replaces, so the earliest index keeps a tie
	function automatic fp_item_t window_max();
		fp_item_t m;
		m.value = win_buf[0];
		m.index = '0;
		for (int i = 1; i < `FP_WINDOW_LEN; i++) begin
			if (order_key(win_buf[i]) > order_key(m.value)) begin
				m.value = win_buf[i];
				m.index = win_index_t'(i);
			end
		end
		return m;
	endfunction

	//////////////////////////////////////////////////
	// Drivers and checks

	task automatic drive_sample(input fp_word_t v);
		@(negedge clk);
		sample_valid = 1'b1;
		sample = v;
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(negedge clk);
			sample_valid = 1'b0;
			abort = 1'b0;
		end
	endtask

	// Gap of 0..max_gap idle cycles after each sample
	task automatic send_window(input int max_gap);
		for (int i = 0; i < `FP_WINDOW_LEN; i++) begin
			drive_sample(win_buf[i]);
			if (max_gap > 0)
				drive_idle(next_rand() % (max_gap + 1));
		end
		exp_q.push_back(window_max());
	endtask

	task automatic check_results();
		fp_item_t e;
		fp_item_t g;
		int n;
		n = 0;
		while (got_q.size() < exp_q.size()) begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				$display("Timeout: %0d results expected, only %0d arrived",
					exp_q.size(), got_q.size());
				$display("** FAIL **");
				$finish;
			end
		end
		// Room for a stray pulse
		repeat (4) @(posedge clk);
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			if (g != e) begin
				errors++;
				$display("Error at %0t: expected %h index %0d, got %h index %0d",
					$time, e.value, e.index, g.value, g.index);
			end
		end
		if (got_q.size() != 0) begin
			errors++;
			$display("Error at %0t: %0d unexpected results", $time, got_q.size());
			got_q.delete();
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_start);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests

	task automatic test_reset_idle();
		int e0;
		e0 = errors;
		repeat (10) begin
			@(negedge clk);
			if (result_valid !== 1'b0 || busy !== 1'b0 || result !== '0) begin
				errors++;
				$display("Error at %0t: outputs not idle after reset", $time);
			end
		end
		finish_test("reset and idle", e0);
	endtask

	task automatic test_positive_window();
		fp_word_t vals [8] = '{32'h3f800000, 32'h40200000, 32'h3f400000, 32'h42c80000,
			32'h40400000, 32'h42c7fae1, 32'h42c80001, 32'h3a83126f};
		int e0;
		int n;
		e0 = errors;
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = vals[i % 8];
		send_window(0);
		// Falling edges counted from the last drive
		n = 0;
		do begin
			drive_idle(1);
			n++;
		end while (!result_valid && n < 10);
		if (n != 3) begin
			errors++;
			$display("Error at %0t: result_valid after %0d cycles, expected 3", $time, n);
		end
		drive_idle(1);
		if (result_valid) begin
			errors++;
			$display("Error at %0t: result_valid high for more than one cycle", $time);
		end
		check_results();
		finish_test("positive window", e0);
	endtask

	task automatic test_mixed_signs();
		fp_word_t mixed [8] = '{32'hc0a00000, 32'h40400000, 32'hc2c80000, 32'h40000000,
			32'h40600000, 32'hbf000000, 32'h3e800000, 32'hc47a0000};
		fp_word_t negs [8] = '{32'hc0a00000, 32'hbf400000, 32'hc2c80000, 32'hbe000000,
			32'hc0000000, 32'hbdcccccd, 32'hc0400000, 32'hbf000000};
		int e0;
		e0 = errors;
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = mixed[i % 8];
		send_window(0);
		// All negative, smallest magnitude on top
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = negs[i % 8];
		send_window(0);
		drive_idle(1);
		check_results();
		finish_test("mixed and negative windows", e0);
	endtask

	task automatic test_ties();
		fp_word_t dups [8] = '{32'h3f800000, 32'h40000000, 32'hc0000000, 32'h3f000000,
			32'h3fc00000, 32'h40000000, 32'h3e000000, 32'h40000000};
		fp_word_t zeros [8] = '{32'h80000000, 32'hbf800000, 32'h80000000, 32'h00000000,
			32'hc0000000, 32'h80000000, 32'h00000000, 32'hbf000000};
		fp_word_t negzero [8] = '{32'hbf800000, 32'h80000000, 32'hc0000000, 32'h80000000,
			32'hbe000000, 32'h80000000, 32'hc1000000, 32'h80000000};
		int e0;
		e0 = errors;
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = dups[i % 8];
		send_window(0);
		// +0 above -0
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = zeros[i % 8];
		send_window(1);
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = negzero[i % 8];
		send_window(0);
		drive_idle(1);
		check_results();
		finish_test("ties and signed zeros", e0);
	endtask

	task automatic test_random();
		int e0;
		e0 = errors;
		// First half back to back, second half with gaps
		for (int w = 0; w < 20; w++) begin
			for (int i = 0; i < `FP_WINDOW_LEN; i++)
				win_buf[i] = rand_word();
			send_window(w < 10 ? 0 : 3);
		end
		drive_idle(1);
		check_results();
		finish_test("random windows", e0);
	endtask

	task automatic test_abort();
		fp_word_t vals [8] = '{32'h40a00000, 32'h3f800000, 32'h40000000, 32'h40400000,
			32'hc0800000, 32'h3f000000, 32'h409ccccd, 32'hc0e00000};
		int e0;
		e0 = errors;
		// Partial window holds the largest value
		drive_sample(32'h4f000000);
		drive_sample(32'h3f800000);
		drive_sample(32'h40000000);
		@(negedge clk);
		// Window open before the abort
		if (busy !== 1'b1) begin
			errors++;
			$display("Error at %0t: busy low during a window", $time);
		end
		abort = 1'b1;
		// Masked by abort
		sample_valid = 1'b1;
		sample = 32'h7f000000;
		drive_idle(1);
		if (busy) begin
			errors++;
			$display("Error at %0t: busy still high after abort", $time);
		end
		drive_idle(10);
		check_results();
		// Maximum at index 0 only if counting restarted
		for (int i = 0; i < `FP_WINDOW_LEN; i++)
			win_buf[i] = vals[i % 8];
		send_window(0);
		drive_idle(1);
		check_results();
		finish_test("abort", e0);
	endtask

	initial begin
		reset = 1'b1;
		sample_valid = 1'b0;
		sample = '0;
		abort = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_idle();
		test_positive_window();
		test_mixed_signs();
		test_ties();
		test_random();
		test_abort();
		$display("Tests passed: %0d, failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- files.f
+incdir+src
src/fp_max_pkg.sv
src/fp_comp.sv
src/window_counter.sv
src/reduce_ctrl.sv
src/max_accum.sv
src/fp_max_top.sv
bench/tb_fp_max.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_fp_max
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run and fail unless the pass line is in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
